/* all.f */
+incdir+.
sdramPkg.sv
countdownTimer.sv
initSequencer.sv
refreshScheduler.sv
sdramCommandArbiter.sv
sdramController.sv
sdramController_properties.sv
tb_sdramController.sv

/* countdownTimer.sv */
// Loadable down-counter that holds at zero and flags done while empty
`timescale 1ns/100ps
`default_nettype none

module countdownTimer
#(
	parameter int Width = 16
)
(
	input wire Clock,
	input wire Reset_L,
	input wire load,                       // takes loadValue on the next edge
	input wire [Width-1:0] loadValue,
	output logic done
);

	logic [Width-1:0] count;

	always_ff @(posedge Clock, negedge Reset_L)
	begin
		if (!Reset_L)
			count <= '0;                   // comes out of reset already expired
		else if (load)
			count <= loadValue;
		else if (count != '0)
			count <= count - 1'b1;         // stop at zero, no wrap
	end

	assign done = (count == '0);

endmodule

`default_nettype wire

/* initSequencer.sv */
// Power-up initialisation FSM: wait, precharge all, refresh burst and mode set
`timescale 1ns/100ps
`include "sdram_consts.svh"
`default_nettype none

module initSequencer
(
	input wire Clock,
	input wire Reset_L,
	output sdramPkg::sdramCmd_t initCmd,   // command for the arbiter, unregistered
	output logic initBusy                  // high from reset until the last mode NOP
);

	localparam int CountWidth = 4;

	// the timer load cycle and the zero cycle both show as power-up at the pins
	localparam int PowerUpWait = `SDRAM_POWERUP_CYCLES - 2;
	localparam logic [`SDRAM_TIMER_WIDTH-1:0] PowerUpLoad =
		PowerUpWait[`SDRAM_TIMER_WIDTH-1:0];

	localparam int RefreshLastInt = `SDRAM_INIT_REFRESHES - 1;
	localparam int RefreshNopLastInt = `SDRAM_REFRESH_NOPS - 1;
	localparam int ModeNopLastInt = `SDRAM_MODE_NOPS - 1;
	localparam logic [CountWidth-1:0] RefreshLast = RefreshLastInt[CountWidth-1:0];
	localparam logic [CountWidth-1:0] RefreshNopLast = RefreshNopLastInt[CountWidth-1:0];
	localparam logic [CountWidth-1:0] ModeNopLast = ModeNopLastInt[CountWidth-1:0];

	sdramPkg::initState_e state;
	sdramPkg::initState_e nextState;
	logic waitStarted;                     // power-up timer has been loaded
	logic timerLoad;
	logic timerDone;
	logic [CountWidth-1:0] refreshCount;   // completed refresh groups
	logic [CountWidth-1:0] nopCount;       // NOPs issued in the current tail

	////////////////////
	// power-up wait timer
	////////////////////

	assign timerLoad = (state == sdramPkg::stPowerWait) && !waitStarted;   // once per reset

	countdownTimer
	#(
		.Width(`SDRAM_TIMER_WIDTH)
	)
	i_powerUpTimer
	(
		.Clock(Clock),
		.Reset_L(Reset_L),
		.load(timerLoad),
		.loadValue(PowerUpLoad),
		.done(timerDone)
	);

	////////////////////
	// state and counters
	////////////////////

	always_ff @(posedge Clock, negedge Reset_L)
	begin
		if (!Reset_L)
		begin
			state <= sdramPkg::stPowerWait;
			waitStarted <= 1'b0;
			refreshCount <= '0;
			nopCount <= '0;
		end
		else
		begin
			state <= nextState;
			if (timerLoad)
				waitStarted <= 1'b1;
			// counts while a NOP tail continues, clears on the way out
			if ((state == sdramPkg::stRefreshNop || state == sdramPkg::stModeNop) &&
				nextState == state)
				nopCount <= nopCount + 1'b1;
			else
				nopCount <= '0;
			if (state == sdramPkg::stRefreshNop && nextState == sdramPkg::stRefresh)
				refreshCount <= refreshCount + 1'b1;   // another group starts
		end
	end

	always_comb
	begin
		nextState = state;                 // hold unless told otherwise
		unique case (state)
			sdramPkg::stPowerWait:
				if (waitStarted && timerDone)
					nextState = sdramPkg::stFirstNop;
			sdramPkg::stFirstNop:
				nextState = sdramPkg::stPrecharge;
			sdramPkg::stPrecharge:
				nextState = sdramPkg::stPrechargeNop;
			sdramPkg::stPrechargeNop:
				nextState = sdramPkg::stRefresh;
			sdramPkg::stRefresh:
				nextState = sdramPkg::stRefreshNop;
			sdramPkg::stRefreshNop:
				if (nopCount == RefreshNopLast)
				begin
					if (refreshCount == RefreshLast)
						nextState = sdramPkg::stModeSet;   // last group done
					else
						nextState = sdramPkg::stRefresh;
				end
			sdramPkg::stModeSet:
				nextState = sdramPkg::stModeNop;
			sdramPkg::stModeNop:
				if (nopCount == ModeNopLast)
					nextState = sdramPkg::stDone;
			default:
				nextState = state;                     // stDone holds
		endcase
	end

	////////////////////
	// command out
	////////////////////

	always_comb
	begin
		initCmd = '{op: sdramPkg::opNop, addr: '0, bank: '0};
		unique case (state)
			sdramPkg::stPowerWait:
				initCmd.op = sdramPkg::opPowerUp;
			sdramPkg::stPrecharge:
			begin
				initCmd.op = sdramPkg::opPrechargeAll;
				initCmd.addr[10] = 1'b1;           // all banks
			end
			sdramPkg::stRefresh:
				initCmd.op = sdramPkg::opAutoRefresh;
			sdramPkg::stModeSet:
			begin
				initCmd.op = sdramPkg::opModeSet;
				initCmd.addr = `SDRAM_MODE_WORD;   // CL2, BL1, bank stays zero
			end
			default:
				initCmd.op = sdramPkg::opNop;
		endcase
	end

	assign initBusy = (state != sdramPkg::stDone);

endmodule

`default_nettype wire

/* refreshScheduler.sv */
// Periodic refresh: interval timer and the precharge, refresh and NOP sequence
`timescale 1ns/100ps
`include "sdram_consts.svh"
`default_nettype none

module refreshScheduler
(
	input wire Clock,
	input wire Reset_L,
	input wire initBusy,                   // init still owns the bus
	output sdramPkg::sdramCmd_t refreshCmd,
	output logic refreshBusy               // precharge through last tail NOP
);

	localparam int CountWidth = 4;

	// zero cycle plus the state step gives interval+1 cycles at the pins
	localparam int IntervalLoadInt = `SDRAM_REFRESH_INTERVAL - 1;
	localparam logic [`SDRAM_TIMER_WIDTH-1:0] IntervalLoad =
		IntervalLoadInt[`SDRAM_TIMER_WIDTH-1:0];
	localparam int TailNopLastInt = `SDRAM_REFRESH_NOPS - 1;
	localparam logic [CountWidth-1:0] TailNopLast = TailNopLastInt[CountWidth-1:0];

	sdramPkg::refreshState_e state;
	sdramPkg::refreshState_e nextState;
	logic initBusyQ;                       // initBusy one clock late
	logic initFall;
	logic lastTailNop;
	logic timerLoad;
	logic timerDone;
	logic [CountWidth-1:0] nopCount;

	assign initFall = initBusyQ && !initBusy;    // init just finished
	assign lastTailNop = (state == sdramPkg::stTailNop) && (nopCount == TailNopLast);
	assign timerLoad = initFall || lastTailNop;

	countdownTimer
	#(
		.Width(`SDRAM_TIMER_WIDTH)
	)
	i_intervalTimer
	(
		.Clock(Clock),
		.Reset_L(Reset_L),
		.load(timerLoad),
		.loadValue(IntervalLoad),
		.done(timerDone)
	);

	always_ff @(posedge Clock, negedge Reset_L)
	begin
		if (!Reset_L)
		begin
			state <= sdramPkg::stIdle;
			initBusyQ <= 1'b1;             // init always starts busy
			nopCount <= '0;
		end
		else
		begin
			state <= nextState;
			initBusyQ <= initBusy;
			if (state == sdramPkg::stTailNop && !lastTailNop)
				nopCount <= nopCount + 1'b1;
			else
				nopCount <= '0;
		end
	end

	always_comb
	begin
		nextState = state;
		refreshCmd = '{op: sdramPkg::opNop, addr: '0, bank: '0};
		unique case (state)
			sdramPkg::stIdle:
				// timer sits at zero from reset, so wait until init has let go
				if (timerDone && !initBusyQ)
					nextState = sdramPkg::stRefPrecharge;
			sdramPkg::stRefPrecharge:
			begin
				refreshCmd.op = sdramPkg::opPrechargeAll;
				refreshCmd.addr[10] = 1'b1;
				nextState = sdramPkg::stGapNop;
			end
			sdramPkg::stGapNop:
				nextState = sdramPkg::stRefAutoRefresh;
			sdramPkg::stRefAutoRefresh:
			begin
				refreshCmd.op = sdramPkg::opAutoRefresh;
				nextState = sdramPkg::stTailNop;
			end
			default:
				if (lastTailNop)
					nextState = sdramPkg::stIdle;   // timer reloads here too
		endcase
	end

	assign refreshBusy = (state != sdramPkg::stIdle);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/bash
# compile with Verilator, run, and pass only if the pass message shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_sdramController -f all.f -o simv &&
./obj_dir/simv +verilator+error+limit+100 | tee /dev/stderr |
	grep 'All tests passed!' > /dev/null &&
echo 'simulation passed' ||
{ echo 'simulation failed'; exit 1; }

/* sdramCommandArbiter.sv */
// Fixed-priority command select, registered onto the SDRAM pins and CPU reset out
`timescale 1ns/100ps
`default_nettype none

module sdramCommandArbiter
(
	input wire Clock,
	input wire Reset_L,
	input wire sdramPkg::sdramCmd_t initCmd,
	input wire initBusy,
	input wire sdramPkg::sdramCmd_t refreshCmd,
	input wire refreshBusy,
	output logic SDram_CKE_H,
	output logic SDram_CS_L,
	output logic SDram_RAS_L,
	output logic SDram_CAS_L,
	output logic SDram_WE_L,
	output logic [12:0] SDram_Addr,
	output logic [1:0] SDram_BA,
	output logic ResetOut_L                // CPU held in reset until init ends
);

	sdramPkg::sdramCmd_t selCmd;           // winner this cycle
	sdramPkg::sdramCmd_t pinCmd;           // what the pins show

	////////////////////
	// select
	////////////////////

	always_comb
	begin
		if (initBusy)
			selCmd = initCmd;              // init always wins
		else if (refreshBusy)
			selCmd = refreshCmd;
		else
			selCmd = '{op: sdramPkg::opNop, addr: '0, bank: '0};
	end

	////////////////////
	// pin register
	////////////////////

	always_ff @(posedge Clock, negedge Reset_L)
	begin
		if (!Reset_L)
		begin
			pinCmd <= '{op: sdramPkg::opPowerUp, addr: '0, bank: '0};   // CKE, CS low
			ResetOut_L <= 1'b0;
		end
		else
		begin
			pinCmd <= selCmd;
			ResetOut_L <= !initBusy;
		end
	end

	// opcode bits straight onto the control pins
	assign {SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L} = pinCmd.op;
	assign SDram_Addr = pinCmd.addr;
	assign SDram_BA = pinCmd.bank;

endmodule

`default_nettype wire

/* sdramController.sv */
// SDRAM controller top: init sequencer and refresh scheduler sharing one pin bus
`timescale 1ns/100ps
`default_nettype none

module sdramController
(
	input wire Clock,
	input wire Reset_L,
	output logic SDram_CKE_H,
	output logic SDram_CS_L,
	output logic SDram_RAS_L,
	output logic SDram_CAS_L,
	output logic SDram_WE_L,
	output logic [12:0] SDram_Addr,
	output logic [1:0] SDram_BA,
	output logic ResetOut_L
);

	sdramPkg::sdramCmd_t initCmd;
	sdramPkg::sdramCmd_t refreshCmd;
	logic initBusy;
	logic refreshBusy;

	initSequencer i_initSequencer
	(
		.Clock(Clock),
		.Reset_L(Reset_L),
		.initCmd(initCmd),
		.initBusy(initBusy)
	);

	// refresh only starts once initBusy has dropped
	refreshScheduler i_refreshScheduler
	(
		.Clock(Clock),
		.Reset_L(Reset_L),
		.initBusy(initBusy),
		.refreshCmd(refreshCmd),
		.refreshBusy(refreshBusy)
	);

	sdramCommandArbiter i_sdramCommandArbiter
	(
		.Clock(Clock),
		.Reset_L(Reset_L),
		.initCmd(initCmd),
		.initBusy(initBusy),
		.refreshCmd(refreshCmd),
		.refreshBusy(refreshBusy),
		.SDram_CKE_H(SDram_CKE_H),
		.SDram_CS_L(SDram_CS_L),
		.SDram_RAS_L(SDram_RAS_L),
		.SDram_CAS_L(SDram_CAS_L),
		.SDram_WE_L(SDram_WE_L),
		.SDram_Addr(SDram_Addr),
		.SDram_BA(SDram_BA),
		.ResetOut_L(ResetOut_L)
	);

endmodule

`default_nettype wire

/* sdramController_properties.sv */
// Pin protocol assertions for the SDRAM controller, bound onto the top level
`timescale 1ns/100ps
`default_nettype none

module sdramController_properties
(
	input wire Clock,
	input wire Reset_L,
	input wire SDram_CKE_H,
	input wire SDram_CS_L,
	input wire SDram_RAS_L,
	input wire SDram_CAS_L,
	input wire SDram_WE_L,
	input wire [12:0] SDram_Addr,
	input wire ResetOut_L
);

	int assertFails = 0;   // failed assertion count, read by the testbench
	logic [4:0] pinOp;

	assign pinOp = {SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L};

	// precharge only ever targets all banks
	prechargeAllBanks: assert property (@(posedge Clock) disable iff (!Reset_L)
		(pinOp == sdramPkg::opPrechargeAll) |-> SDram_Addr[10])
	else
	begin
		assertFails++;
		$error("precharge issued with A10 low");
	end

	// clock enable only drops through reset
	ckeHeld: assert property (@(posedge Clock) disable iff (!Reset_L)
		!$fell(SDram_CKE_H))
	else
	begin
		assertFails++;
		$error("CKE fell while Reset_L was high");
	end

	// once the CPU is out of reset it stays out
	resetOutHeld: assert property (@(posedge Clock) disable iff (!Reset_L)
		!$fell(ResetOut_L))
	else
	begin
		assertFails++;
		$error("ResetOut_L fell while Reset_L was high");
	end

endmodule

bind sdramController sdramController_properties i_properties
(
	.Clock(Clock),
	.Reset_L(Reset_L),
	.SDram_CKE_H(SDram_CKE_H),
	.SDram_CS_L(SDram_CS_L),
	.SDram_RAS_L(SDram_RAS_L),
	.SDram_CAS_L(SDram_CAS_L),
	.SDram_WE_L(SDram_WE_L),
	.SDram_Addr(SDram_Addr),
	.ResetOut_L(ResetOut_L)
);

`default_nettype wire

/* sdramPkg.sv */
// SDRAM command opcodes, sequencer state encodings and the shared command bus
`default_nettype none

package sdramPkg;

	////////////////////
	// command opcodes
	////////////////////

	// bit order is CKE, CS_L, RAS_L, CAS_L, WE_L
	typedef enum logic [4:0]
	{
		opPowerUp      = 5'b00000,   // CKE and CS low while the part powers up
		opNop          = 5'b10111,
		opPrechargeAll = 5'b10010,   // needs A10 high
		opAutoRefresh  = 5'b10001,
		opModeSet      = 5'b10000    // mode word on addr with bank zero
	} sdramOp_e;

	// one 20-bit command as it goes to the pins
	typedef struct packed
	{
		sdramOp_e op;
		logic [12:0] addr;            // row address with A10 as the all-banks flag
		logic [1:0] bank;
	} sdramCmd_t;

	////////////////////
	// sequencer states
	////////////////////

	typedef enum logic [3:0]
	{
		stPowerWait,                  // CKE and CS low until the power-up timer runs out
		stFirstNop,
		stPrecharge,
		stPrechargeNop,
		stRefresh,                    // one auto refresh per group
		stRefreshNop,
		stModeSet,
		stModeNop,
		stDone                        // parked here until the next reset
	} initState_e;

	// refresh scheduler states
	typedef enum logic [2:0]
	{
		stIdle,                       // waiting for the interval timer
		stRefPrecharge,
		stGapNop,
		stRefAutoRefresh,
		stTailNop
	} refreshState_e;

endpackage

`default_nettype wire

/* sdram_consts.svh */
// SDRAM controller timing, count and mode register constants
`ifndef SDRAM_CONSTS_SVH
`define SDRAM_CONSTS_SVH

`default_nettype none

////////////////////
// power-up and initialisation
////////////////////

`define SDRAM_POWERUP_CYCLES 8       // power-up wait at the pins, cut short for simulation
`define SDRAM_INIT_REFRESHES 10      // auto refreshes issued during init
`define SDRAM_REFRESH_NOPS 3         // NOPs trailing every auto refresh
`define SDRAM_MODE_NOPS 3            // NOPs trailing the mode register set

////////////////////
// periodic refresh
////////////////////

`define SDRAM_REFRESH_INTERVAL 375   // cycles from timer load to next refresh start
`define SDRAM_TIMER_WIDTH 16         // width of both countdown timers

////////////////////
// mode register
////////////////////

// field layout: A12..A10 reserved, A9 write burst mode, A8..A7 op mode,
// A6..A4 CAS latency, A3 burst type, A2..A0 burst length
`define SDRAM_CAS_LATENCY 3'b010     // CAS latency 2
`define SDRAM_BURST_LENGTH 3'b000    // burst length 1
`define SDRAM_BURST_SEQ 1'b0         // sequential burst
`define SDRAM_MODE_WORD {3'b000, 1'b0, 2'b00, `SDRAM_CAS_LATENCY, `SDRAM_BURST_SEQ, \
	`SDRAM_BURST_LENGTH}

`default_nettype wire

`endif

/* tb_sdramController.sv */
// Directed testbench for the SDRAM controller covering reset, init order, refresh timing and restart
`timescale 1ns/100ps
`include "sdram_consts.svh"
`default_nettype none

module tb_sdramController;

	localparam logic [12:0] AllBanksAddr = 13'h0400;         // A10 alone
	localparam logic [12:0] ModeWord = 13'h0020;             // CL2 in A6..A4, BL1, sequential
	localparam int RefreshGap = `SDRAM_REFRESH_INTERVAL + 1; // timer load to next precharge
	localparam int WaitLimit = 1000;                         // cycles before a wait gives up

	logic Clock;
	logic Reset_L;
	logic SDram_CKE_H;
	logic SDram_CS_L;
	logic SDram_RAS_L;
	logic SDram_CAS_L;
	logic SDram_WE_L;
	logic [12:0] SDram_Addr;
	logic [1:0] SDram_BA;
	logic ResetOut_L;
	sdramPkg::sdramOp_e pinOp;   // pins decoded back into an opcode
	int errorCount;
	int testCount;
	int assertFails;

	sdramController i_sdramController
	(
		.Clock(Clock),
		.Reset_L(Reset_L),
		.SDram_CKE_H(SDram_CKE_H),
		.SDram_CS_L(SDram_CS_L),
		.SDram_RAS_L(SDram_RAS_L),
		.SDram_CAS_L(SDram_CAS_L),
		.SDram_WE_L(SDram_WE_L),
		.SDram_Addr(SDram_Addr),
		.SDram_BA(SDram_BA),
		.ResetOut_L(ResetOut_L)
	);

	// CKE, CS_L, RAS_L, CAS_L, WE_L
	assign pinOp = sdramPkg::sdramOp_e'({SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L,
		SDram_WE_L});

	initial
	begin
		Clock = 1'b0;
		forever
			#10 Clock = ~Clock;   // 20 ns period
	end

	////////////////////
	// stepping and compares
	////////////////////

	// next rising edge, then sample at the falling edge where the pins have settled
	task automatic stepCycle();
		@(posedge Clock);
		@(negedge Clock);
	endtask

	task automatic driveReset(input logic level);
		@(posedge Clock);
		#1;
		Reset_L = level;
	endtask

	task automatic checkOp(input string where, input sdramPkg::sdramOp_e expected);
		if (pinOp !== expected)
		begin
			errorCount++;
			$display("[FAIL] %s pinOp: expected %h, got %h", where, expected, pinOp);
		end
	endtask

	task automatic checkAddr(input string where, input logic [12:0] expected);
		if (SDram_Addr !== expected)
		begin
			errorCount++;
			$display("[FAIL] %s SDram_Addr: expected %h, got %h", where, expected, SDram_Addr);
		end
	endtask

	task automatic checkBank(input string where, input logic [1:0] expected);
		if (SDram_BA !== expected)
		begin
			errorCount++;
			$display("[FAIL] %s SDram_BA: expected %h, got %h", where, expected, SDram_BA);
		end
	endtask

	task automatic checkLevel(input string where, input logic expected);
		if (ResetOut_L !== expected)
		begin
			errorCount++;
			$display("[FAIL] %s ResetOut_L: expected %h, got %h", where, expected, ResetOut_L);
		end
	endtask

	task automatic checkCycles(input string where, input int expected, input int actual);
		if (actual != expected)
		begin
			errorCount++;
			$display("[FAIL] %s refreshStartCycle: expected %h, got %h", where, expected, actual);
		end
	endtask

	// one full pin snapshot
	task automatic expectPins(input string where, input sdramPkg::sdramOp_e op,
		input logic [12:0] addr, input logic resetOut);
		checkOp(where, op);
		checkAddr(where, addr);
		checkBank(where, 2'b00);          // nothing here ever picks a bank
		checkLevel(where, resetOut);
	endtask

	task automatic finishTest(input string name, input int startErrors);
		testCount++;
		$display("%s: %s, %0d errors", name, (errorCount == startErrors) ? "ok" : "FAILED",
			errorCount - startErrors);
	endtask

	////////////////////
	// sequence checks
	////////////////////

	// starts right after Reset_L rises and ends on the cycle ResetOut_L goes high
	task automatic checkInitSequence(input string where);
		for (int i = 0; i < `SDRAM_POWERUP_CYCLES; i++)
		begin
			stepCycle();
			expectPins({where, " power-up"}, sdramPkg::opPowerUp, 13'h0000, 1'b0);
		end
		stepCycle();
		expectPins({where, " first nop"}, sdramPkg::opNop, 13'h0000, 1'b0);
		stepCycle();
		expectPins({where, " precharge"}, sdramPkg::opPrechargeAll, AllBanksAddr, 1'b0);
		stepCycle();
		expectPins({where, " precharge nop"}, sdramPkg::opNop, 13'h0000, 1'b0);
		for (int g = 0; g < `SDRAM_INIT_REFRESHES; g++)
		begin
			stepCycle();
			expectPins({where, " refresh"}, sdramPkg::opAutoRefresh, 13'h0000, 1'b0);
			for (int n = 0; n < `SDRAM_REFRESH_NOPS; n++)
			begin
				stepCycle();
				expectPins({where, " refresh nop"}, sdramPkg::opNop, 13'h0000, 1'b0);
			end
		end
		stepCycle();
		expectPins({where, " mode set"}, sdramPkg::opModeSet, ModeWord, 1'b0);
		for (int n = 0; n < `SDRAM_MODE_NOPS; n++)
		begin
			stepCycle();
			expectPins({where, " mode nop"}, sdramPkg::opNop, 13'h0000, 1'b0);
		end
		stepCycle();                      // CPU let out of reset one cycle later
		expectPins({where, " init end"}, sdramPkg::opNop, 13'h0000, 1'b1);
	endtask

	// idle NOPs until the next command, which must be the refresh precharge
	task automatic waitRefreshStart(input string where, input int expectedCycles);
		int cycles;
		cycles = 1;
		stepCycle();
		while (pinOp == sdramPkg::opNop && cycles < WaitLimit)
		begin
			stepCycle();
			cycles++;
		end
		if (pinOp == sdramPkg::opNop)
		begin
			errorCount++;
			$display("%s: no refresh started within %0d cycles", where, cycles);
		end
		else
		begin
			checkCycles(where, expectedCycles, cycles);
			expectPins({where, " precharge"}, sdramPkg::opPrechargeAll, AllBanksAddr, 1'b1);
		end
	endtask

	task automatic checkRefreshBody(input string where);
		stepCycle();
		expectPins({where, " gap nop"}, sdramPkg::opNop, 13'h0000, 1'b1);
		stepCycle();
		expectPins({where, " refresh"}, sdramPkg::opAutoRefresh, 13'h0000, 1'b1);
		for (int n = 0; n < `SDRAM_REFRESH_NOPS; n++)
		begin
			stepCycle();
			expectPins({where, " tail nop"}, sdramPkg::opNop, 13'h0000, 1'b1);
		end
	endtask

	////////////////////
	// directed tests
	////////////////////

	task automatic testResetState();
		int startErrors;
		startErrors = errorCount;
		repeat (5)
		begin
			stepCycle();
			expectPins("reset", sdramPkg::opPowerUp, 13'h0000, 1'b0);
		end
		finishTest("reset state", startErrors);
	endtask

	task automatic testInitOrder();
		int startErrors;
		startErrors = errorCount;
		driveReset(1'b1);
		checkInitSequence("init");
		finishTest("init order", startErrors);
	endtask

	task automatic testFirstRefresh();
		int startErrors;
		startErrors = errorCount;
		// the interval timer loads on the same edge that raises ResetOut_L
		waitRefreshStart("first refresh", RefreshGap);
		checkRefreshBody("first refresh");
		finishTest("first refresh", startErrors);
	endtask

	task automatic testRefreshPeriod();
		int startErrors;
		startErrors = errorCount;
		waitRefreshStart("second refresh", RefreshGap);   // counted from the last tail NOP
		checkRefreshBody("second refresh");
		finishTest("refresh period", startErrors);
	endtask

	task automatic testRestart();
		int startErrors;
		startErrors = errorCount;
		repeat (100)
			stepCycle();                  // well inside the interval
		driveReset(1'b0);
		@(negedge Clock);                 // asynchronous reset shows within the same cycle
		expectPins("restart reset", sdramPkg::opPowerUp, 13'h0000, 1'b0);
		repeat (4)
		begin
			stepCycle();
			expectPins("restart reset", sdramPkg::opPowerUp, 13'h0000, 1'b0);
		end
		driveReset(1'b1);
		checkInitSequence("restart");
		finishTest("restart on reset", startErrors);
	endtask

	initial
	begin
		Reset_L = 1'b0;
		errorCount = 0;
		testCount = 0;
		testResetState();
		testInitOrder();
		testFirstRefresh();
		testRefreshPeriod();
		testRestart();
		assertFails = i_sdramController.i_properties.assertFails;
		$display("%0d tests run, %0d check errors, %0d assertion failures", testCount,
			errorCount, assertFails);
		if (errorCount == 0 && assertFails == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// whole run is about 1100 cycles
	initial
	begin
		#200000;
		$display("Watchdog expired before the tests completed");
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire
